// ==== design/tlk2711_pkg.sv ====
package tlk2711_pkg;

    //////////////////////////////////////////////////
    // lane code words
    //////////////////////////////////////////////////

    // {D5.6, K28.5}
    localparam logic [15:0] COMMA_WORD = 16'hC5BC;
    // {K28.2, K27.7}
    localparam logic [15:0] SOF_WORD   = 16'h5CFB;
    // {K29.7, K30.7}
    localparam logic [15:0] EOF_WORD   = 16'hFDFE;

    localparam logic [15:0] HEAD_0     = 16'hEB90;
    localparam logic [15:0] HEAD_1     = 16'hE116;
    localparam logic [7:0]  TX_IND     = 8'h81;
    localparam logic [7:0]  FILE_END   = 8'h01;
    localparam logic [3:0]  SWEEP_CODE = 4'h1;

    //////////////////////////////////////////////////
    // frame and buffer sizes
    //////////////////////////////////////////////////

    localparam logic [15:0] SYNC_WORDS      = 16'd6;
    localparam logic [19:0] BACKWARD_WORDS  = 20'd257;
    localparam int          FIFO_ENTRIES    = 128;
    localparam int          FIFO_AW         = $clog2(FIFO_ENTRIES);
    localparam int          MAX_FRAME_BYTES = 512;

    // tx mode codes
    // any other code keeps the sequencer idle
    localparam logic [2:0]  MODE_NORMAL = 3'd0;
    localparam logic [2:0]  MODE_SWEEP  = 3'd3;

    typedef enum logic [3:0] {
        IDLE, SYNC, SOF, HEAD, FILE_SIGN, FRAME_NUM,
        LENGTH, DATA, CHECKSUM, EOF, GAP, INTERRUPT
    } tx_state_t;

    typedef struct packed {
        logic [7:0] type_byte;
        logic [7:0] end_byte;
    } sign_norm_t;

    typedef struct packed {
        logic       rsvd_hi;
        logic       file_end;
        logic       rsvd_lo;
        logic       channel;
        logic [3:0] code;
        logic [7:0] frame_hi;
    } sign_sweep_t;

    // file-sign word in its normal and sweep layouts
    typedef union packed {
        sign_norm_t  norm;
        sign_sweep_t sweep;
    } file_sign_t;

endpackage

// ==== design/tx_payload_fifo.sv ====
`timescale 1ns/1ps

module tx_payload_fifo (
    input  logic        clk,
    input  logic        i_soft_reset,
    input  logic        i_dma_valid,
    input  logic [63:0] i_dma_data,
    input  logic        i_rd_en,
    output logic [15:0] o_rd_word,
    output logic [9:0]  o_level,
    output logic        o_dma_credit
);
    import tlk2711_pkg::*;

    // four lane words per entry with the lowest word first
    logic [3:0][15:0]   mem [FIFO_ENTRIES];

    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_entry;
    logic [1:0]         rd_half;
    logic [9:0]         level;
    logic               entry_drained;

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_dma_valid) begin
            mem[wr_ptr] <= i_dma_data;
        end
    end

    // head word is visible without a read request
    assign o_rd_word = mem[rd_entry][rd_half];

    //////////////////////////////////////////////////
    // pointers, level and credit return
    //////////////////////////////////////////////////

    assign entry_drained = i_rd_en && (rd_half == 2'd3);

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            wr_ptr       <= '0;
            rd_entry     <= '0;
            rd_half      <= 2'd0;
            level        <= 10'd0;
            o_dma_credit <= 1'b0;
        end else begin
            if (i_dma_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_rd_en) begin
                rd_half <= rd_half + 2'd1;
            end
            if (entry_drained) begin
                rd_entry <= rd_entry + 1'b1;
            end
            // a write adds four words and a read takes one
            level <= level + (i_dma_valid ? 10'd4 : 10'd0) - (i_rd_en ? 10'd1 : 10'd0);
            o_dma_credit <= entry_drained;
        end
    end

    assign o_level = level;

endmodule

// ==== design/tx_frame_fsm.sv ====
`timescale 1ns/1ps

module tx_frame_fsm (
    input  logic                   clk,
    input  logic                   i_soft_reset,
    input  logic                   i_tx_start,
    input  logic [2:0]             i_tx_mode,
    input  logic [15:0]            i_tx_packet_body,
    input  logic [15:0]            i_tx_packet_tail,
    input  logic [23:0]            i_tx_body_num,
    input  logic [19:0]            i_backward_cycle_num,
    input  logic [15:0]            i_tx_intr_width,
    input  logic [9:0]             i_level,
    output logic                   o_rd_en,
    output tlk2711_pkg::tx_state_t o_state,
    output logic                   o_head_sel,
    output logic [23:0]            o_frame_num,
    output logic [15:0]            o_valid_len,
    output logic                   o_last_frame,
    output logic [2:0]             o_tx_mode,
    output logic                   o_channel_id,
    output logic                   o_tx_interrupt
);
    import tlk2711_pkg::*;

    tx_state_t   state;
    logic        start_pending;
    logic        tail_sent;
    logic        channel_id;
    logic [19:0] word_cnt;
    logic [23:0] frame_cnt;

    // configuration captured by the start pulse
    logic [2:0]  mode_q;
    logic [15:0] body_q;
    logic [15:0] tail_q;
    logic [23:0] body_num_q;
    logic [19:0] backward_q;
    logic [15:0] intr_q;

    logic        mode_ok;
    logic [15:0] need_words;
    logic        payload_ready;
    logic [19:0] gap_len;
    logic        gap_done;
    logic        data_done;
    logic        intr_done;

    always_ff @(posedge clk) begin
        if (i_tx_start) begin
            mode_q     <= i_tx_mode;
            body_q     <= i_tx_packet_body;
            tail_q     <= i_tx_packet_tail;
            body_num_q <= i_tx_body_num;
            backward_q <= i_backward_cycle_num;
            intr_q     <= i_tx_intr_width;
        end
    end

    assign mode_ok       = (mode_q == MODE_NORMAL) || (mode_q == MODE_SWEEP);
    // frame_cnt already points at the next frame outside a frame
    assign need_words    = {1'b0, o_valid_len[15:1]};
    assign payload_ready = {6'd0, i_level} >= need_words;
    assign gap_len       = (mode_q == MODE_SWEEP) ? backward_q : BACKWARD_WORDS;
    assign gap_done      = (word_cnt + 20'd1) >= gap_len;
    assign data_done     = (word_cnt + 20'd1) == {4'd0, need_words};
    assign intr_done     = (word_cnt + 20'd1) >= {4'd0, intr_q};

    //////////////////////////////////////////////////
    // sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            state         <= IDLE;
            start_pending <= 1'b0;
            tail_sent     <= 1'b0;
            channel_id    <= 1'b0;
            word_cnt      <= 20'd0;
            frame_cnt     <= 24'd0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_pending && mode_ok && payload_ready) begin
                        state         <= SYNC;
                        start_pending <= 1'b0;
                        channel_id    <= 1'b0;
                        word_cnt      <= 20'd0;
                    end
                end
                SYNC: begin
                    word_cnt <= word_cnt + 20'd1;
                    if (word_cnt == {4'd0, SYNC_WORDS} - 20'd1) begin
                        state <= SOF;
                    end
                end
                SOF: begin
                    word_cnt <= 20'd0;
                    state    <= HEAD;
                end
                // word_cnt[0] picks the header word
                HEAD: begin
                    word_cnt <= word_cnt + 20'd1;
                    if (word_cnt[0]) begin
                        state <= FILE_SIGN;
                    end
                end
                FILE_SIGN: begin
                    if (mode_q == MODE_SWEEP) begin
                        channel_id <= ~channel_id;
                    end
                    state <= FRAME_NUM;
                end
                FRAME_NUM: state <= LENGTH;
                LENGTH: begin
                    word_cnt <= 20'd0;
                    state    <= (need_words == 16'd0) ? CHECKSUM : DATA;
                end
                DATA: begin
                    word_cnt <= word_cnt + 20'd1;
                    if (data_done) begin
                        state <= CHECKSUM;
                    end
                end
                CHECKSUM: state <= EOF;
                EOF: begin
                    word_cnt <= 20'd0;
                    if (o_last_frame) begin
                        frame_cnt <= 24'd0;
                        tail_sent <= 1'b1;
                    end else begin
                        frame_cnt <= frame_cnt + 24'd1;
                    end
                    state <= GAP;
                end
                // holds here with comma words until the next payload is buffered
                GAP: begin
                    if (!gap_done) begin
                        word_cnt <= word_cnt + 20'd1;
                    end else if (tail_sent) begin
                        word_cnt  <= 20'd0;
                        tail_sent <= 1'b0;
                        state     <= INTERRUPT;
                    end else if (payload_ready) begin
                        state <= SOF;
                    end
                end
                INTERRUPT: begin
                    word_cnt <= word_cnt + 20'd1;
                    if (intr_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
            if (i_tx_start) begin
                start_pending <= 1'b1;
            end
        end
    end

    assign o_state        = state;
    assign o_rd_en        = (state == DATA);
    assign o_head_sel     = word_cnt[0];
    assign o_frame_num    = frame_cnt;
    assign o_last_frame   = (frame_cnt == body_num_q);
    assign o_valid_len    = o_last_frame ? tail_q : body_q;
    assign o_tx_mode      = mode_q;
    assign o_channel_id   = channel_id;
    assign o_tx_interrupt = (state == INTERRUPT);

endmodule

// ==== design/tx_word_builder.sv ====
`timescale 1ns/1ps

module tx_word_builder (
    input  logic                   clk,
    input  logic                   i_soft_reset,
    input  tlk2711_pkg::tx_state_t i_state,
    input  logic                   i_head_sel,
    input  logic [23:0]            i_frame_num,
    input  logic [15:0]            i_valid_len,
    input  logic                   i_last_frame,
    input  logic [2:0]             i_tx_mode,
    input  logic                   i_channel_id,
    input  logic [15:0]            i_rd_word,
    output logic [15:0]            o_2711_txd,
    output logic                   o_2711_tkmsb,
    output logic                   o_2711_tklsb
);
    import tlk2711_pkg::*;

    file_sign_t  sign;
    logic [15:0] word;
    logic [1:0]  kflags;
    logic [15:0] checksum;

    always_comb begin
        sign = '0;
        if (i_tx_mode == MODE_SWEEP) begin
            sign.sweep.file_end = i_last_frame;
            sign.sweep.channel  = i_channel_id;
            sign.sweep.code     = SWEEP_CODE;
            sign.sweep.frame_hi = i_frame_num[23:16];
        end else begin
            sign.norm.type_byte = TX_IND;
            sign.norm.end_byte  = i_last_frame ? FILE_END : 8'h00;
        end
    end

    // kflags is {msb, lsb}
    always_comb begin
        word   = COMMA_WORD;
        kflags = 2'b00;
        case (i_state)
            SOF: begin
                word   = SOF_WORD;
                kflags = 2'b11;
            end
            HEAD:      word = i_head_sel ? HEAD_1 : HEAD_0;
            FILE_SIGN: word = sign;
            FRAME_NUM: word = i_frame_num[15:0];
            LENGTH:    word = i_valid_len;
            DATA:      word = i_rd_word;
            CHECKSUM:  word = checksum;
            EOF: begin
                word   = EOF_WORD;
                kflags = 2'b11;
            end
            default:   kflags = 2'b01;
        endcase
    end

    //////////////////////////////////////////////////
    // checksum and lane registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            checksum     <= 16'd0;
            o_2711_txd   <= COMMA_WORD;
            o_2711_tkmsb <= 1'b0;
            o_2711_tklsb <= 1'b1;
        end else begin
            if (i_state == SOF) begin
                checksum <= 16'd0;
            end else if (i_state inside {FILE_SIGN, FRAME_NUM, LENGTH, DATA}) begin
                checksum <= checksum + word;
            end
            o_2711_txd   <= word;
            o_2711_tkmsb <= kflags[1];
            o_2711_tklsb <= kflags[0];
        end
    end

endmodule

// ==== design/tlk2711_tx.sv ====
`timescale 1ns/1ps

module tlk2711_tx (
    input  logic        clk,
    input  logic        i_soft_reset,
    input  logic        i_tx_start,
    input  logic [2:0]  i_tx_mode,
    input  logic [15:0] i_tx_packet_body,
    input  logic [15:0] i_tx_packet_tail,
    input  logic [23:0] i_tx_body_num,
    input  logic [19:0] i_backward_cycle_num,
    input  logic [15:0] i_tx_intr_width,
    input  logic        i_dma_valid,
    input  logic [63:0] i_dma_data,
    output logic        o_dma_credit,
    output logic        o_tx_interrupt,
    output logic [15:0] o_2711_txd,
    output logic        o_2711_tkmsb,
    output logic        o_2711_tklsb
);
    import tlk2711_pkg::*;

    // fifo side
    logic [15:0] rd_word;
    logic [9:0]  level;
    logic        rd_en;

    // sequencer to builder
    tx_state_t   tx_state;
    logic        head_sel;
    logic [23:0] frame_num;
    logic [15:0] valid_len;
    logic        last_frame;
    logic [2:0]  tx_mode;
    logic        channel_id;

    tx_payload_fifo u_fifo (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_dma_valid  (i_dma_valid),
        .i_dma_data   (i_dma_data),
        .i_rd_en      (rd_en),
        .o_rd_word    (rd_word),
        .o_level      (level),
        .o_dma_credit (o_dma_credit)
    );

    tx_frame_fsm u_fsm (
        .clk                  (clk),
        .i_soft_reset         (i_soft_reset),
        .i_tx_start           (i_tx_start),
        .i_tx_mode            (i_tx_mode),
        .i_tx_packet_body     (i_tx_packet_body),
        .i_tx_packet_tail     (i_tx_packet_tail),
        .i_tx_body_num        (i_tx_body_num),
        .i_backward_cycle_num (i_backward_cycle_num),
        .i_tx_intr_width      (i_tx_intr_width),
        .i_level              (level),
        .o_rd_en              (rd_en),
        .o_state              (tx_state),
        .o_head_sel           (head_sel),
        .o_frame_num          (frame_num),
        .o_valid_len          (valid_len),
        .o_last_frame         (last_frame),
        .o_tx_mode            (tx_mode),
        .o_channel_id         (channel_id),
        .o_tx_interrupt       (o_tx_interrupt)
    );

    tx_word_builder u_builder (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_state      (tx_state),
        .i_head_sel   (head_sel),
        .i_frame_num  (frame_num),
        .i_valid_len  (valid_len),
        .i_last_frame (last_frame),
        .i_tx_mode    (tx_mode),
        .i_channel_id (channel_id),
        .i_rd_word    (rd_word),
        .o_2711_txd   (o_2711_txd),
        .o_2711_tkmsb (o_2711_tkmsb),
        .o_2711_tklsb (o_2711_tklsb)
    );

endmodule

// ==== tests/tx_lane_monitor.sv ====
`timescale 1ns/1ps

module tx_lane_monitor (
    input  logic        clk,
    input  logic        i_soft_reset,
    input  logic        i_tx_start,
    input  logic        i_dma_valid,
    input  logic [63:0] i_dma_data,
    input  logic        i_dma_credit,
    input  logic        i_tx_interrupt,
    input  logic [15:0] i_txd,
    input  logic        i_tkmsb,
    input  logic        i_tklsb,
    output int          o_error_count,
    output int          o_files_done
);
    import tlk2711_pkg::*;

    // configuration of the running test
    string       test_name = "reset";
    int          mode;
    int          body_bytes;
    int          tail_bytes;
    int          body_num;
    int          gap_words;
    int          intr_width;
    int          exp_frames;

    // payload taken off the DMA bus in lane order
    logic [15:0] payload_q [$];

    int          errors = 0;
    int          files = 0;
    int          rst_cycles = 0;
    int          field;
    int          words_left;
    int          frames_seen;
    int          gap_cnt;
    int          intr_cnt;
    int          credits;
    bit          file_active;
    bit          tail_done;
    bit          intr_prev;
    logic [15:0] sum;

    assign o_error_count = errors;
    assign o_files_done  = files;

    task automatic begin_test(input string name, input int t_mode, input int t_body,
                              input int t_tail, input int t_body_num, input int t_backward,
                              input int t_intr, input int t_frames);
        test_name  = name;
        mode       = t_mode;
        body_bytes = t_body;
        tail_bytes = t_tail;
        body_num   = t_body_num;
        gap_words  = (t_mode == int'(MODE_SWEEP)) ? t_backward : int'(BACKWARD_WORDS);
        intr_width = t_intr;
        exp_frames = t_frames;
    endtask

    task automatic check_value(input string what, input int exp, input int act);
        if (exp != act) begin
            errors++;
            $display("** Error [%s] %s: expected %0h, actual %0h", test_name, what, exp, act);
        end
    endtask

    task automatic report_fault(input string what);
        errors++;
        $display("[%s] %s at %0t ns", test_name, what, $time);
    endtask

    task automatic clear_file();
        field       = 0;
        frames_seen = 0;
        gap_cnt     = 0;
        intr_cnt    = 0;
        tail_done   = 1'b0;
        intr_prev   = 1'b0;
    endtask

    // credits held by the source and the payload it wrote
    task automatic take_dma();
        if (i_dma_credit) begin
            credits++;
        end
        if (i_dma_valid) begin
            if (credits == 0) begin
                report_fault("DMA source wrote an entry without holding a credit");
            end
            credits--;
            payload_q.push_back(i_dma_data[15:0]);
            payload_q.push_back(i_dma_data[31:16]);
            payload_q.push_back(i_dma_data[47:32]);
            payload_q.push_back(i_dma_data[63:48]);
        end
        if (credits > FIFO_ENTRIES) begin
            report_fault("FIFO returned more credits than entries were written");
        end
    endtask

    //////////////////////////////////////////////////
    // lane decoding
    //////////////////////////////////////////////////

    task automatic decode_lane();
        logic [1:0]  k;
        logic        last;
        logic [15:0] exp_word;
        file_sign_t  sign;
        k    = {i_tkmsb, i_tklsb};
        last = (frames_seen == body_num);
        sign = i_txd;
        if (field == 0) begin
            if (k == 2'b11 && i_txd == SOF_WORD) begin
                if (!file_active) begin
                    report_fault("SOF seen while no file was started");
                end
                if (frames_seen > 0 && gap_cnt < gap_words) begin
                    report_fault($sformatf("gap of %0d comma words, below %0d",
                                           gap_cnt, gap_words));
                end
                sum   = 16'd0;
                field = 1;
            end else if (k == 2'b01 && i_txd == COMMA_WORD) begin
                gap_cnt++;
            end else begin
                report_fault($sformatf("word %h with k flags %b outside a frame", i_txd, k));
            end
        end else if (field == 8) begin
            check_value("EOF word", int'(EOF_WORD), int'(i_txd));
            check_value("EOF k flags", 3, int'(k));
            frames_seen++;
            gap_cnt = 0;
            field   = 0;
            if (last) begin
                tail_done   = 1'b1;
                file_active = 1'b0;
            end
        end else begin
            // only SOF, EOF and comma words carry K flags
            check_value($sformatf("frame %0d k flags", frames_seen), 0, int'(k));
            case (field)
                1: begin
                    check_value("HEAD_0", int'(HEAD_0), int'(i_txd));
                    field = 2;
                end
                2: begin
                    check_value("HEAD_1", int'(HEAD_1), int'(i_txd));
                    field = 3;
                end
                3: begin
                    if (mode == int'(MODE_SWEEP)) begin
                        check_value("sign reserved", 0, int'({sign.sweep.rsvd_hi,
                                                              sign.sweep.rsvd_lo}));
                        check_value("sign end bit", int'(last), int'(sign.sweep.file_end));
                        check_value("sign channel", frames_seen % 2, int'(sign.sweep.channel));
                        check_value("sign sweep code", int'(SWEEP_CODE), int'(sign.sweep.code));
                        check_value("sign frame high byte", (frames_seen >> 16) % 256,
                                    int'(sign.sweep.frame_hi));
                    end else begin
                        check_value("sign type byte", int'(TX_IND), int'(sign.norm.type_byte));
                        check_value("sign end byte", last ? int'(FILE_END) : 0,
                                    int'(sign.norm.end_byte));
                    end
                    sum   = sum + i_txd;
                    field = 4;
                end
                4: begin
                    check_value("frame number", frames_seen % 65536, int'(i_txd));
                    sum   = sum + i_txd;
                    field = 5;
                end
                5: begin
                    words_left = (last ? tail_bytes : body_bytes) / 2;
                    check_value($sformatf("frame %0d length", frames_seen),
                                last ? tail_bytes : body_bytes, int'(i_txd));
                    sum   = sum + i_txd;
                    field = (words_left > 0) ? 6 : 7;
                end
                6: begin
                    if (payload_q.size() == 0) begin
                        report_fault("payload word on the lane that the source never sent");
                    end else begin
                        exp_word = payload_q.pop_front();
                        check_value($sformatf("frame %0d payload", frames_seen),
                                    int'(exp_word), int'(i_txd));
                    end
                    sum = sum + i_txd;
                    words_left--;
                    if (words_left == 0) begin
                        field = 7;
                    end
                end
                default: begin
                    check_value($sformatf("frame %0d checksum", frames_seen),
                                int'(sum), int'(i_txd));
                    field = 8;
                end
            endcase
        end
    endtask

    // end of file when the pulse after the last EOF falls
    task automatic watch_interrupt();
        if (i_tx_interrupt) begin
            if (!tail_done && intr_cnt == 0) begin
                report_fault("interrupt raised before the last EOF");
            end
            intr_cnt++;
        end else if (intr_prev) begin
            check_value("interrupt width", intr_width, intr_cnt);
            check_value("frame count", exp_frames, frames_seen);
            check_value("credits after drain", FIFO_ENTRIES, credits);
            clear_file();
            files++;
        end
        intr_prev = i_tx_interrupt;
    endtask

    always @(posedge clk) begin
        if (i_soft_reset) begin
            rst_cycles++;
            // lane registers settle one edge into reset
            if (rst_cycles > 1) begin
                check_value("lane word in reset", int'(COMMA_WORD), int'(i_txd));
                check_value("k flags in reset", 1, int'({i_tkmsb, i_tklsb}));
                check_value("interrupt in reset", 0, int'(i_tx_interrupt));
            end
            clear_file();
            file_active = 1'b0;
            credits     = FIFO_ENTRIES;
            payload_q.delete();
        end else begin
            rst_cycles = 0;
            take_dma();
            if (i_tx_start) begin
                file_active = 1'b1;
            end
            decode_lane();
            watch_interrupt();
        end
    end

endmodule

// ==== tests/tb_tlk2711_tx.sv ====
`timescale 1ns/1ps

module tb_tlk2711_tx;
    import tlk2711_pkg::*;

    localparam int CLK_HALF   = 20;
    localparam int RST_CYCLES = 16;
    localparam int MAX_TESTS  = 16;

    logic        clk = 1'b0;
    logic        soft_reset;
    logic        tx_start;
    logic [2:0]  tx_mode;
    logic [15:0] packet_body;
    logic [15:0] packet_tail;
    logic [23:0] body_num;
    logic [19:0] backward_num;
    logic [15:0] intr_width;
    logic        dma_valid;
    logic [63:0] dma_data;
    logic        dma_credit;
    logic        tx_interrupt;
    logic [15:0] txd;
    logic        tkmsb;
    logic        tklsb;
    int          mon_errors;
    int          files_done;

    // per test mode, body, tail, body_num, backward, intr width and frames
    string       t_name [MAX_TESTS];
    int          t_cfg  [MAX_TESTS][7];
    int          num_tests = 0;
    int          src_errors = 0;
    int          credits;
    integer      seed = 32'h8b66_229c;
    longint      limit_cycles;

    always #CLK_HALF clk = ~clk;

    tlk2711_tx dut (
        .clk                  (clk),
        .i_soft_reset         (soft_reset),
        .i_tx_start           (tx_start),
        .i_tx_mode            (tx_mode),
        .i_tx_packet_body     (packet_body),
        .i_tx_packet_tail     (packet_tail),
        .i_tx_body_num        (body_num),
        .i_backward_cycle_num (backward_num),
        .i_tx_intr_width      (intr_width),
        .i_dma_valid          (dma_valid),
        .i_dma_data           (dma_data),
        .o_dma_credit         (dma_credit),
        .o_tx_interrupt       (tx_interrupt),
        .o_2711_txd           (txd),
        .o_2711_tkmsb         (tkmsb),
        .o_2711_tklsb         (tklsb)
    );

    tx_lane_monitor mon (
        .clk            (clk),
        .i_soft_reset   (soft_reset),
        .i_tx_start     (tx_start),
        .i_dma_valid    (dma_valid),
        .i_dma_data     (dma_data),
        .i_dma_credit   (dma_credit),
        .i_tx_interrupt (tx_interrupt),
        .i_txd          (txd),
        .i_tkmsb        (tkmsb),
        .i_tklsb        (tklsb),
        .o_error_count  (mon_errors),
        .o_files_done   (files_done)
    );

    task automatic load_tests();
        int    fd;
        int    n;
        string line;
        string name;
        fd = $fopen("tests/tx_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/tx_stimulus.txt");
            src_errors++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %d %d %d %d %d %d %d", name, t_cfg[num_tests][0],
                        t_cfg[num_tests][1], t_cfg[num_tests][2], t_cfg[num_tests][3],
                        t_cfg[num_tests][4], t_cfg[num_tests][5], t_cfg[num_tests][6]);
            if (n == 8 && num_tests < MAX_TESTS) begin
                t_name[num_tests] = name;
                num_tests++;
            end
        end
        $fclose(fd);
        if (num_tests == 0) begin
            $display("the stimulus file holds no tests");
            src_errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // one file with start pulse and credited payload
    //////////////////////////////////////////////////

    task automatic run_file(input int idx);
        int words;
        int entries;
        int sent;
        int done_before;
        int after_sof;
        bit abort;
        bit finished;
        words   = t_cfg[idx][3] * (t_cfg[idx][1] / 2) + t_cfg[idx][2] / 2;
        entries = (words + 3) / 4;
        // zero frames expected marks a reset inside frame 0
        abort   = (t_cfg[idx][6] == 0);
        if (!abort && (words % 4) != 0) begin
            $display("test %s: %0d payload words do not fill whole entries", t_name[idx], words);
            src_errors++;
        end
        mon.begin_test(t_name[idx], t_cfg[idx][0], t_cfg[idx][1], t_cfg[idx][2],
                       t_cfg[idx][3], t_cfg[idx][4], t_cfg[idx][5], t_cfg[idx][6]);
        tx_mode      = 3'(t_cfg[idx][0]);
        packet_body  = 16'(t_cfg[idx][1]);
        packet_tail  = 16'(t_cfg[idx][2]);
        body_num     = 24'(t_cfg[idx][3]);
        backward_num = 20'(t_cfg[idx][4]);
        intr_width   = 16'(t_cfg[idx][5]);
        tx_start     = 1'b1;
        sent         = 0;
        after_sof    = -1;
        finished     = 1'b0;
        done_before  = files_done;
        while (!finished) begin
            @(negedge clk);
            tx_start = 1'b0;
            if (dma_credit) begin
                credits++;
            end
            if (sent < entries && credits > 0) begin
                dma_valid = 1'b1;
                dma_data  = {$random(seed), $random(seed)};
                credits--;
                sent++;
            end else begin
                dma_valid = 1'b0;
            end
            if (abort) begin
                if (after_sof >= 0) begin
                    after_sof++;
                end else if (tkmsb && txd == SOF_WORD) begin
                    after_sof = 0;
                end
                finished = (after_sof == 5);
            end else begin
                finished = (files_done != done_before) && (sent == entries);
            end
        end
        dma_valid = 1'b0;
        if (abort) begin
            soft_reset = 1'b1;
            repeat (4) @(negedge clk);
            soft_reset = 1'b0;
            credits    = FIFO_ENTRIES;
        end
    endtask

    initial begin
        int i;
        int gap;
        soft_reset   = 1'b1;
        tx_start     = 1'b0;
        tx_mode      = MODE_NORMAL;
        packet_body  = 16'd0;
        packet_tail  = 16'd0;
        body_num     = 24'd0;
        backward_num = 20'd0;
        intr_width   = 16'd0;
        dma_valid    = 1'b0;
        dma_data     = 64'd0;
        credits      = FIFO_ENTRIES;
        load_tests();

        // watchdog at three times the nominal length of all tests
        limit_cycles = RST_CYCLES;
        for (i = 0; i < num_tests; i++) begin
            gap = (t_cfg[i][0] == int'(MODE_SWEEP)) ? t_cfg[i][4] : int'(BACKWARD_WORDS);
            limit_cycles += longint'(t_cfg[i][3] + 1) * longint'(t_cfg[i][1] / 2 + 8 + gap)
                            + longint'(SYNC_WORDS) + longint'(t_cfg[i][5]);
        end
        limit_cycles = limit_cycles * 3;
        fork
            begin
                #(limit_cycles * 2 * CLK_HALF);
                $display("watchdog: run still going after %0d cycles, the DUT stalled",
                         limit_cycles);
                $display("TEST FAILED");
                $finish;
            end
        join_none

        repeat (RST_CYCLES) @(negedge clk);
        soft_reset = 1'b0;
        for (i = 0; i < num_tests; i++) begin
            run_file(i);
        end
        repeat (4) @(negedge clk);
        $display("%0d errors (%0d from the monitor, %0d from the source)",
                 mon_errors + src_errors, mon_errors, src_errors);
        if (mon_errors + src_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/tx_stimulus.txt ====
# name  mode  body_bytes  tail_bytes  body_num  backward_cycles  intr_width  frames  (decimal)
# mode 0 normal, 3 sweep; frames 0 means a soft reset inside frame 0
norm_basic       0   16    8   2    0   5  3
sweep_small      3   32   24   3   12   3  4
abort_mid        0   64   32   1    0   4  0
norm_after_rst   0  512    8   2    0   1  3
sweep_long_gap   3   40    8   5  300  16  6
norm_one_frame   0  100   16   0    0   2  1

// ==== flist.f ====
design/tlk2711_pkg.sv
design/tx_payload_fifo.sv
design/tx_frame_fsm.sv
design/tx_word_builder.sv
design/tlk2711_tx.sv
tests/tx_lane_monitor.sv
tests/tb_tlk2711_tx.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the TLK2711 transmit testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --top-module tb_tlk2711_tx -f flist.f -Mdir "$OBJ"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/Vtb_tlk2711_tx" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0
